// ==== verilog/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// ==========================================================================
	// word and index types
	// ==========================================================================

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [4:0] shamt_t;

	// jal target register
	localparam regIdx_t linkReg = 5'd31;
	// boot vector
	localparam word_t defaultResetPc = 32'hbfc00000;

	// major opcodes still decoded
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opLui     = 6'h0f
	} opcode_t;

	// function field under opSpecial
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnSlt  = 6'h2a,
		fnSltu = 6'h2b
	} funct_t;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluLui
	} aluOp_t;

	// ==========================================================================
	// stage packets
	// ==========================================================================

	typedef struct packed {
		aluOp_t  aluOp;
		logic    useImm;
		word_t   imm;
		shamt_t  shamt;
		logic    regWrite;
		regIdx_t writeReg;
		logic    isBranch;
		logic    branchOnNe;
		logic    isJump;
		logic    link;
	} decodeCtrl_t;

	typedef struct packed {
		logic  take;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic    regWrite;
		regIdx_t writeReg;
		word_t   result;
	} bypass_t;

	typedef struct packed {
		logic    valid;
		word_t   pc;
		aluOp_t  aluOp;
		word_t   srcA;
		word_t   srcB;
		shamt_t  shamt;
		logic    regWrite;
		regIdx_t writeReg;
		logic    link;
	} execPacket_t;

	typedef struct packed {
		logic    valid;
		word_t   pc;
		logic    regWrite;
		regIdx_t writeReg;
		word_t   result;
	} retire_t;

endpackage

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
	parameter cpuPkg::word_t resetPc = cpuPkg::defaultResetPc
) (
	input  logic              clk,
	input  logic              rstN,
	input  cpuPkg::redirect_t redirect,
	output cpuPkg::word_t     pcF,
	output cpuPkg::word_t     pcD,
	output logic              dValid
);

	cpuPkg::word_t pcNext;

	// sequential fetch unless decode steers elsewhere
	// redirect lands one slot late, giving the delay slot
	always_comb begin
		if (redirect.take) begin
			pcNext = redirect.target;
		end else begin
			pcNext = pcF + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= resetPc;
		end else begin
			pcF <= pcNext;
		end
	end

	// address of the word now on instrF
	always_ff @(posedge clk) begin
		pcD <= pcF;
	end

	// first fetch comes back one cycle after reset drops
	always_ff @(posedge clk) begin
		if (!rstN) begin
			dValid <= 1'b0;
		end else begin
			dValid <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  cpuPkg::word_t       instr,
	output cpuPkg::decodeCtrl_t ctrl
);

	cpuPkg::opcode_t op;
	cpuPkg::funct_t  fn;
	cpuPkg::regIdx_t rtField;
	cpuPkg::regIdx_t rdField;
	cpuPkg::regIdx_t dest;
	logic [15:0]     immField;
	logic            writes;
	logic            zeroExt;

	// instruction fields
	assign op       = cpuPkg::opcode_t'(instr[31:26]);
	assign fn       = cpuPkg::funct_t'(instr[5:0]);
	assign rtField  = instr[20:16];
	assign rdField  = instr[15:11];
	assign immField = instr[15:0];

	always_comb begin
		ctrl       = '0;
		ctrl.aluOp = cpuPkg::aluAdd;
		dest       = rtField;
		writes     = 1'b0;
		zeroExt    = 1'b0;
		case (op)
			cpuPkg::opSpecial: begin
				// r-type writes rd
				dest   = rdField;
				writes = 1'b1;
				case (fn)
					cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd:  ctrl.aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOr:   ctrl.aluOp = cpuPkg::aluOr;
					cpuPkg::fnXor:  ctrl.aluOp = cpuPkg::aluXor;
					cpuPkg::fnSlt:  ctrl.aluOp = cpuPkg::aluSlt;
					cpuPkg::fnSltu: ctrl.aluOp = cpuPkg::aluSltu;
					cpuPkg::fnSll:  ctrl.aluOp = cpuPkg::aluSll;
					cpuPkg::fnSrl:  ctrl.aluOp = cpuPkg::aluSrl;
					// unknown function, retire with no write
					default: writes = 1'b0;
				endcase
			end
			cpuPkg::opAddiu: begin
				ctrl.useImm = 1'b1;
				writes      = 1'b1;
			end
			cpuPkg::opAndi: begin
				ctrl.aluOp  = cpuPkg::aluAnd;
				ctrl.useImm = 1'b1;
				writes      = 1'b1;
				zeroExt     = 1'b1;
			end
			cpuPkg::opOri: begin
				ctrl.aluOp  = cpuPkg::aluOr;
				ctrl.useImm = 1'b1;
				writes      = 1'b1;
				zeroExt     = 1'b1;
			end
			cpuPkg::opLui: begin
				ctrl.aluOp  = cpuPkg::aluLui;
				ctrl.useImm = 1'b1;
				writes      = 1'b1;
				zeroExt     = 1'b1;
			end
			cpuPkg::opBeq: ctrl.isBranch = 1'b1;
			cpuPkg::opBne: begin
				ctrl.isBranch   = 1'b1;
				ctrl.branchOnNe = 1'b1;
			end
			cpuPkg::opJ: ctrl.isJump = 1'b1;
			cpuPkg::opJal: begin
				// link value picked up in execute
				ctrl.isJump = 1'b1;
				ctrl.link   = 1'b1;
				dest        = cpuPkg::linkReg;
				writes      = 1'b1;
			end
			default: writes = 1'b0;
		endcase
		// writes to r0 dropped here, so bypass never carries r0
		ctrl.regWrite = writes && (dest != 5'd0);
		ctrl.writeReg = dest;
		ctrl.shamt    = instr[10:6];
		if (zeroExt) begin
			ctrl.imm = {16'h0000, immField};
		end else begin
			ctrl.imm = {{16{immField[15]}}, immField};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic            clk,
	input  logic            rstN,
	input  cpuPkg::retire_t writePort,
	input  cpuPkg::regIdx_t rs,
	input  cpuPkg::regIdx_t rt,
	output cpuPkg::word_t   rsData,
	output cpuPkg::word_t   rtData
);

	cpuPkg::word_t regs [32];
	logic          writeEn;

	// retire slot writes only when it carries a real register
	assign writeEn = writePort.valid && writePort.regWrite && (writePort.writeReg != 5'd0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writePort.writeReg] <= writePort.result;
		end
	end

	// write-through, same-cycle retire seen by decode
	// r0 pinned to zero
	always_comb begin
		if (rs == 5'd0) begin
			rsData = '0;
		end else if (writeEn && (writePort.writeReg == rs)) begin
			rsData = writePort.result;
		end else begin
			rsData = regs[rs];
		end
		if (rt == 5'd0) begin
			rtData = '0;
		end else if (writeEn && (writePort.writeReg == rt)) begin
			rtData = writePort.result;
		end else begin
			rtData = regs[rt];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic                clk,
	input  logic                rstN,
	input  cpuPkg::word_t       instrF,
	input  cpuPkg::word_t       pcD,
	input  logic                dValid,
	input  cpuPkg::bypass_t     bypass,
	input  cpuPkg::retire_t     writePort,
	output cpuPkg::redirect_t   redirect,
	output cpuPkg::execPacket_t execPkt
);

	cpuPkg::decodeCtrl_t ctrl;
	cpuPkg::regIdx_t     rs;
	cpuPkg::regIdx_t     rt;
	cpuPkg::word_t       rsData;
	cpuPkg::word_t       rtData;
	cpuPkg::word_t       srcA;
	cpuPkg::word_t       srcRt;
	cpuPkg::word_t       pcPlus4;
	cpuPkg::word_t       branchTarget;
	cpuPkg::word_t       jumpTarget;
	logic                operandsEqual;
	logic                branchTaken;
	cpuPkg::execPacket_t execNext;

	// instruction word arrives straight from the synchronous fetch
	assign rs = instrF[25:21];
	assign rt = instrF[20:16];

	instrDecoder decoder0 (
		.instr(instrF),
		.ctrl (ctrl)
	);

	regFile regs0 (
		.clk      (clk),
		.rstN     (rstN),
		.writePort(writePort),
		.rs       (rs),
		.rt       (rt),
		.rsData   (rsData),
		.rtData   (rtData)
	);

	// ==========================================================================
	// operand forwarding
	// ==========================================================================

	// execute result wins, then regFile write-through, then stored value
	// bypass never names r0, decoder already cleared those writes
	always_comb begin
		srcA  = rsData;
		srcRt = rtData;
		if (bypass.regWrite && (bypass.writeReg == rs)) begin
			srcA = bypass.result;
		end
		if (bypass.regWrite && (bypass.writeReg == rt)) begin
			srcRt = bypass.result;
		end
	end

	// ==========================================================================
	// early branch and jump resolution
	// ==========================================================================

	assign pcPlus4       = pcD + 32'd4;
	// offset already sign-extended by the decoder
	assign branchTarget  = pcPlus4 + {ctrl.imm[29:0], 2'b00};
	assign jumpTarget    = {pcPlus4[31:28], instrF[25:0], 2'b00};
	assign operandsEqual = (srcA == srcRt);
	// bne flips the compare
	assign branchTaken   = ctrl.isBranch && (operandsEqual ^ ctrl.branchOnNe);

	always_comb begin
		redirect.take = dValid && (ctrl.isJump || branchTaken);
		if (ctrl.isJump) begin
			redirect.target = jumpTarget;
		end else begin
			redirect.target = branchTarget;
		end
	end

	// ==========================================================================
	// decode to execute register
	// ==========================================================================

	always_comb begin
		execNext.valid    = dValid;
		execNext.pc       = pcD;
		execNext.aluOp    = ctrl.aluOp;
		execNext.srcA     = srcA;
		// immediate ops take imm in place of rt
		execNext.srcB     = ctrl.useImm ? ctrl.imm : srcRt;
		execNext.shamt    = ctrl.shamt;
		execNext.regWrite = ctrl.regWrite;
		execNext.writeReg = ctrl.writeReg;
		execNext.link     = ctrl.link;
	end

	// only valid is cleared, payload follows it
	always_ff @(posedge clk) begin
		execPkt <= execNext;
		if (!rstN) begin
			execPkt.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input  logic                clk,
	input  logic                rstN,
	input  cpuPkg::execPacket_t execPkt,
	output cpuPkg::bypass_t     bypass,
	output cpuPkg::retire_t     retire
);

	cpuPkg::word_t aluOut;
	cpuPkg::word_t result;
	cpuPkg::word_t srcA;
	cpuPkg::word_t srcB;

	assign srcA = execPkt.srcA;
	assign srcB = execPkt.srcB;

	// ==========================================================================
	// ALU
	// ==========================================================================

	always_comb begin
		case (execPkt.aluOp)
			cpuPkg::aluAdd:  aluOut = srcA + srcB;
			cpuPkg::aluSub:  aluOut = srcA - srcB;
			cpuPkg::aluAnd:  aluOut = srcA & srcB;
			cpuPkg::aluOr:   aluOut = srcA | srcB;
			cpuPkg::aluXor:  aluOut = srcA ^ srcB;
			// signed compare
			cpuPkg::aluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
			cpuPkg::aluSltu: aluOut = {31'd0, srcA < srcB};
			// shifts act on rt by the shamt field
			cpuPkg::aluSll:  aluOut = srcB << execPkt.shamt;
			cpuPkg::aluSrl:  aluOut = srcB >> execPkt.shamt;
			// upper half from the zero-extended immediate
			cpuPkg::aluLui:  aluOut = {srcB[15:0], 16'h0000};
			default:         aluOut = '0;
		endcase
	end

	// jal returns past the delay slot
	assign result = execPkt.link ? (execPkt.pc + 32'd8) : aluOut;

	// forward to decode, dead packets never match
	always_comb begin
		bypass.regWrite = execPkt.valid && execPkt.regWrite;
		bypass.writeReg = execPkt.writeReg;
		bypass.result   = result;
	end

	// ==========================================================================
	// retire register
	// ==========================================================================

	always_ff @(posedge clk) begin
		retire.pc       <= execPkt.pc;
		retire.regWrite <= execPkt.regWrite;
		retire.writeReg <= execPkt.writeReg;
		retire.result   <= result;
		if (!rstN) begin
			retire.valid <= 1'b0;
		end else begin
			retire.valid <= execPkt.valid;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpuPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuPipeline #(
	parameter cpuPkg::word_t resetPc = cpuPkg::defaultResetPc
) (
	input  logic            clk,
	input  logic            rstN,
	input  cpuPkg::word_t   instrF,
	output cpuPkg::word_t   pcF,
	output cpuPkg::retire_t retire
);

	cpuPkg::redirect_t   redirect;
	cpuPkg::word_t       pcD;
	logic                dValid;
	cpuPkg::execPacket_t execPkt;
	cpuPkg::bypass_t     bypass;

	// fetch, address out now, word back next cycle
	fetchStage #(
		.resetPc(resetPc)
	) fetch0 (
		.clk     (clk),
		.rstN    (rstN),
		.redirect(redirect),
		.pcF     (pcF),
		.pcD     (pcD),
		.dValid  (dValid)
	);

	// decode also owns the register file, written from retire
	decodeStage decode0 (
		.clk      (clk),
		.rstN     (rstN),
		.instrF   (instrF),
		.pcD      (pcD),
		.dValid   (dValid),
		.bypass   (bypass),
		.writePort(retire),
		.redirect (redirect),
		.execPkt  (execPkt)
	);

	executeStage execute0 (
		.clk    (clk),
		.rstN   (rstN),
		.execPkt(execPkt),
		.bypass (bypass),
		.retire (retire)
	);

endmodule

`default_nettype wire

// ==== verif/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 16
) (
	input  logic resetReq,
	output logic clk,
	output logic rstN
);

	int holdCount;

	initial begin
		clk       = 1'b0;
		rstN      = 1'b0;
		holdCount = resetCycles - 1;
	end

	always #(periodNs / 2) clk = ~clk;

	// reset low for resetCycles edges, restarted by a request
	always @(posedge clk) begin
		if (resetReq) begin
			holdCount <= resetCycles - 1;
			rstN      <= 1'b0;
		end else if (holdCount > 0) begin
			holdCount <= holdCount - 1;
			rstN      <= 1'b0;
		end else begin
			rstN <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verif/cpuAsserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuAsserts (
	input logic            clk,
	input logic            rstN,
	input cpuPkg::word_t   pcF,
	input cpuPkg::retire_t retire
);

	// read by the testbench at the end of the run
	int failures = 0;

	// decoder drops r0 writes before they reach retire
	noR0Write: assert property (@(posedge clk) disable iff (!rstN)
		(retire.valid && retire.regWrite) |-> (retire.writeReg != 5'd0))
	else begin
		$error("retire slot wrote register zero");
		failures++;
	end

	// fetch never sits still once out of reset
	pcMoves: assert property (@(posedge clk)
		(rstN && $past(rstN)) |-> (pcF != $past(pcF)))
	else begin
		$error("pcF kept its value across a cycle");
		failures++;
	end

endmodule

`default_nettype wire

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam cpuPkg::word_t resetPc = cpuPkg::defaultResetPc;
	localparam int clkPeriodNs = 100;
	localparam int memWords    = 64;

	// retire counts per program
	localparam int lenReset  = 6;
	localparam int lenAlu    = 17;
	localparam int lenDep    = 10;
	localparam int lenBranch = 19;
	localparam int lenJump   = 8;
	localparam int lenRandom = 48;
	localparam int totalSteps = lenReset + lenAlu + lenDep + lenBranch + lenJump
		+ 2 * lenRandom;
	localparam int watchdogCycles = 4 * totalSteps + 64;

	logic            clk;
	logic            rstN;
	logic            resetReq;
	cpuPkg::word_t   instrF;
	cpuPkg::word_t   pcF;
	cpuPkg::retire_t retire;

	cpuPkg::word_t   imem [memWords];
	cpuPkg::word_t   progWords [$];
	cpuPkg::retire_t expectQ [$];
	logic            resetTaken = 1'b1;
	logic            checking;
	int              errors;
	int              retireCount;
	int              testCount;
	int              failedTests;

	tbClockGen #(
		.periodNs   (clkPeriodNs),
		.resetCycles(16)
	) clkGen0 (
		.resetReq(resetReq),
		.clk     (clk),
		.rstN    (rstN)
	);

	cpuPipeline #(
		.resetPc(resetPc)
	) dut0 (
		.clk   (clk),
		.rstN  (rstN),
		.instrF(instrF),
		.pcF   (pcF),
		.retire(retire)
	);

	bind cpuPipeline cpuAsserts asserts0 (
		.clk   (clk),
		.rstN  (rstN),
		.pcF   (pcF),
		.retire(retire)
	);

	// ==========================================================================
	// instruction memory and encoders
	// ==========================================================================

	// outside the window reads as nop
	function automatic cpuPkg::word_t fetchWord(input cpuPkg::word_t addr);
		cpuPkg::word_t offset;
		offset = addr - resetPc;
		if ($isunknown(addr) || offset >= 32'(memWords * 4)) begin
			return '0;
		end
		return imem[offset[7:2]];
	endfunction

	// synchronous fetch returns the word for last cycle's pcF
	always @(posedge clk) begin
		instrF <= fetchWord(pcF);
	end

	function automatic cpuPkg::word_t encR(input logic [5:0] fn, input cpuPkg::regIdx_t rd,
		input cpuPkg::regIdx_t rs, input cpuPkg::regIdx_t rt, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic cpuPkg::word_t encI(input logic [5:0] op, input cpuPkg::regIdx_t rt,
		input cpuPkg::regIdx_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpuPkg::word_t encJ(input logic [5:0] op, input cpuPkg::word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic cpuPkg::word_t wordAddr(input int n);
		return resetPc + 32'(n * 4);
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = (i < progWords.size()) ? progWords[i] : '0;
		end
	endtask

	// ==========================================================================
	// ISA reference model
	// ==========================================================================

	// in-order run with one delay slot after every branch or jump
	task automatic predictRetires(input int steps);
		cpuPkg::word_t   regs [32];
		cpuPkg::word_t   pc;
		cpuPkg::word_t   nextPc;
		cpuPkg::word_t   afterNext;
		cpuPkg::word_t   w;
		cpuPkg::word_t   a;
		cpuPkg::word_t   b;
		cpuPkg::word_t   sext;
		cpuPkg::word_t   res;
		cpuPkg::regIdx_t dest;
		logic            writes;
		cpuPkg::retire_t entry;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc     = resetPc;
		nextPc = resetPc + 32'd4;
		repeat (steps) begin
			w         = fetchWord(pc);
			a         = regs[w[25:21]];
			b         = regs[w[20:16]];
			sext      = {{16{w[15]}}, w[15:0]};
			dest      = w[20:16];
			writes    = 1'b1;
			res       = '0;
			afterNext = nextPc + 32'd4;
			case (w[31:26])
				6'h00: begin
					dest = w[15:11];
					case (w[5:0])
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						6'h2b: res = (a < b) ? 32'd1 : 32'd0;
						6'h00: res = b << w[10:6];
						6'h02: res = b >> w[10:6];
						default: writes = 1'b0;
					endcase
				end
				6'h09: res = a + sext;
				// logical immediates zero-extended
				6'h0c: res = a & {16'h0000, w[15:0]};
				6'h0d: res = a | {16'h0000, w[15:0]};
				6'h0f: res = {w[15:0], 16'h0000};
				6'h04, 6'h05: begin
					writes = 1'b0;
					if ((a == b) ^ w[26]) begin
						afterNext = pc + 32'd4 + {sext[29:0], 2'b00};
					end
				end
				6'h02, 6'h03: begin
					writes    = w[26];
					dest      = 5'd31;
					res       = pc + 32'd8;
					afterNext = pc + 32'd4;
					afterNext = {afterNext[31:28], w[25:0], 2'b00};
				end
				default: writes = 1'b0;
			endcase
			entry          = '0;
			entry.valid    = 1'b1;
			entry.pc       = pc;
			entry.regWrite = writes && (dest != 5'd0);
			entry.writeReg = dest;
			entry.result   = res;
			expectQ.push_back(entry);
			if (entry.regWrite) begin
				regs[dest] = res;
			end
			pc     = nextPc;
			nextPc = afterNext;
		end
	endtask

	// ==========================================================================
	// retire checker
	// ==========================================================================

	task automatic reportMismatch(input string field, input cpuPkg::word_t got,
		input cpuPkg::word_t want);
		$display("Mismatch %s: got %h expected %h", field, got, want);
		errors++;
	endtask

	task automatic compareRetire(input cpuPkg::retire_t got, input cpuPkg::retire_t want);
		assert (got.pc === want.pc)
		else reportMismatch("retire.pc", got.pc, want.pc);
		assert (got.regWrite === want.regWrite)
		else reportMismatch("retire.regWrite", 32'(got.regWrite), 32'(want.regWrite));
		// destination and value only matter for a write
		if (want.regWrite) begin
			assert (got.writeReg === want.writeReg)
			else reportMismatch("retire.writeReg", 32'(got.writeReg), 32'(want.writeReg));
			assert (got.result === want.result)
			else reportMismatch("retire.result", got.result, want.result);
		end
	endtask

	// rstN level the DUT acted on at this edge
	always @(posedge clk) begin
		resetTaken <= !rstN;
	end

	// retire and pcF sampled on the falling edge
	always @(negedge clk) begin
		cpuPkg::retire_t want;
		if (resetTaken) begin
			assert (pcF === resetPc)
			else reportMismatch("pcF", pcF, resetPc);
			assert (retire.valid === 1'b0)
			else reportMismatch("retire.valid", 32'(retire.valid), 32'd0);
		end else if (checking && retire.valid === 1'b1) begin
			retireCount++;
			want = expectQ.pop_front();
			compareRetire(retire, want);
		end
	end

	// ==========================================================================
	// test sequencing
	// ==========================================================================

	task automatic runProgram(input string name, input int steps);
		int cycles;
		int errorsBefore;
		loadProgram();
		checking = 1'b0;
		@(posedge clk);
		resetReq <= 1'b1;
		@(posedge clk);
		resetReq <= 1'b0;
		wait (rstN === 1'b0);
		// DUT has taken reset by the second falling edge
		repeat (2) @(negedge clk);
		expectQ.delete();
		predictRetires(steps);
		errorsBefore = errors;
		retireCount  = 0;
		cycles       = 0;
		checking     = 1'b1;
		while (expectQ.size() != 0 && cycles < steps + 64) begin
			@(posedge clk);
			cycles++;
		end
		checking = 1'b0;
		assert (expectQ.size() == 0)
		else begin
			$display("%s: %0d expected retires never arrived", name, expectQ.size());
			errors++;
		end
		expectQ.delete();
		testCount++;
		if (errors != errorsBefore) begin
			failedTests++;
		end
		$display("test %-8s retired %0d, errors %0d", name, retireCount, errors - errorsBefore);
	endtask

	task automatic resetTest();
		progWords.delete();
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h0123));
		progWords.push_back(encI(cpuPkg::opOri, 5'd2, 5'd1, 16'h4500));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd3, 5'd2, 5'd1, 5'd0));
		progWords.push_back('0);
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd4, 5'd0, 16'hffff));
		progWords.push_back(encR(cpuPkg::fnSltu, 5'd5, 5'd1, 5'd4, 5'd0));
		runProgram("reset", lenReset);
	endtask

	task automatic aluTest();
		progWords.delete();
		// r1 negative, r2 = -3, r3 = 0x7fff
		progWords.push_back(encI(cpuPkg::opLui, 5'd1, 5'd0, 16'h8000));
		progWords.push_back(encI(cpuPkg::opOri, 5'd1, 5'd1, 16'h1234));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd2, 5'd0, 16'hfffd));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd3, 5'd0, 16'h7fff));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd4, 5'd1, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSubu, 5'd5, 5'd1, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnAnd, 5'd6, 5'd1, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnOr, 5'd7, 5'd1, 5'd3, 5'd0));
		progWords.push_back(encR(cpuPkg::fnXor, 5'd8, 5'd1, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSlt, 5'd9, 5'd1, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSltu, 5'd10, 5'd1, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSlt, 5'd11, 5'd3, 5'd1, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSll, 5'd12, 5'd0, 5'd2, 5'd4));
		progWords.push_back(encR(cpuPkg::fnSrl, 5'd13, 5'd0, 5'd2, 5'd4));
		progWords.push_back(encI(cpuPkg::opAndi, 5'd14, 5'd2, 16'h8001));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd15, 5'd1, 16'h8000));
		progWords.push_back(encI(cpuPkg::opLui, 5'd16, 5'd0, 16'habcd));
		runProgram("alu", lenAlu);
	endtask

	task automatic dependencyTest();
		progWords.delete();
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h0001));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd2, 5'd1, 5'd1, 5'd0));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd3, 5'd2, 5'd1, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSubu, 5'd4, 5'd3, 5'd2, 5'd0));
		progWords.push_back(encR(cpuPkg::fnXor, 5'd5, 5'd4, 5'd3, 5'd0));
		// write to r0 must vanish
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd0, 5'd5, 16'h0007));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd6, 5'd0, 5'd5, 5'd0));
		progWords.push_back(encR(cpuPkg::fnSll, 5'd7, 5'd0, 5'd6, 5'd3));
		progWords.push_back(encR(cpuPkg::fnOr, 5'd8, 5'd7, 5'd6, 5'd0));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd9, 5'd8, 5'd8, 5'd0));
		runProgram("depend", lenDep);
	endtask

	task automatic branchTest();
		progWords.delete();
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h0003));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd2, 5'd0, 16'h0003));
		progWords.push_back(encI(cpuPkg::opBeq, 5'd2, 5'd1, 16'd2));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd3, 5'd0, 16'h0011));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd4, 5'd0, 16'h0022));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd1, 5'd1, 16'h0001));
		// compare operand from the instruction just before
		progWords.push_back(encI(cpuPkg::opBne, 5'd2, 5'd1, 16'd2));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd5, 5'd0, 16'h0033));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd6, 5'd0, 16'h0044));
		progWords.push_back(encI(cpuPkg::opBeq, 5'd2, 5'd1, 16'd3));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd7, 5'd0, 16'h0055));
		progWords.push_back(encI(cpuPkg::opBne, 5'd1, 5'd1, 16'd2));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd8, 5'd0, 16'h0066));
		// two-pass loop with a backward offset
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd10, 5'd0, 16'h0002));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd10, 5'd10, 16'hffff));
		progWords.push_back(encI(cpuPkg::opBne, 5'd0, 5'd10, 16'hfffe));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd11, 5'd11, 16'h0001));
		runProgram("branch", lenBranch);
	endtask

	task automatic jumpTest();
		progWords.delete();
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd1, 5'd0, 16'h0001));
		progWords.push_back(encJ(cpuPkg::opJal, wordAddr(6)));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd2, 5'd0, 16'h0002));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd3, 5'd0, 16'h0003));
		progWords.push_back('0);
		progWords.push_back('0);
		// link register read two slots after jal
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd4, 5'd31, 5'd0, 5'd0));
		progWords.push_back(encJ(cpuPkg::opJ, wordAddr(10)));
		progWords.push_back(encI(cpuPkg::opOri, 5'd5, 5'd4, 16'h0001));
		progWords.push_back(encI(cpuPkg::opAddiu, 5'd6, 5'd0, 16'h0006));
		progWords.push_back(encR(cpuPkg::fnAddu, 5'd7, 5'd5, 5'd31, 5'd0));
		runProgram("jump", lenJump);
	endtask

	task automatic randomTest(input string name, input int count);
		int              kind;
		cpuPkg::regIdx_t rd;
		cpuPkg::regIdx_t rs;
		cpuPkg::regIdx_t rt;
		logic [15:0]     imm;
		logic [4:0]      sh;
		progWords.delete();
		repeat (count) begin
			kind = $urandom_range(14, 0);
			// few registers, so dependencies are common
			rd   = 5'($urandom_range(7, 0));
			rs   = 5'($urandom_range(7, 0));
			rt   = 5'($urandom_range(7, 0));
			imm  = 16'($urandom);
			sh   = 5'($urandom);
			case (kind)
				0: progWords.push_back(encR(cpuPkg::fnAddu, rd, rs, rt, 5'd0));
				1: progWords.push_back(encR(cpuPkg::fnSubu, rd, rs, rt, 5'd0));
				2: progWords.push_back(encR(cpuPkg::fnAnd, rd, rs, rt, 5'd0));
				3: progWords.push_back(encR(cpuPkg::fnOr, rd, rs, rt, 5'd0));
				4: progWords.push_back(encR(cpuPkg::fnXor, rd, rs, rt, 5'd0));
				5: progWords.push_back(encR(cpuPkg::fnSlt, rd, rs, rt, 5'd0));
				6: progWords.push_back(encR(cpuPkg::fnSltu, rd, rs, rt, 5'd0));
				7: progWords.push_back(encR(cpuPkg::fnSll, rd, 5'd0, rt, sh));
				8: progWords.push_back(encR(cpuPkg::fnSrl, rd, 5'd0, rt, sh));
				9: progWords.push_back(encI(cpuPkg::opAddiu, rt, rs, imm));
				10: progWords.push_back(encI(cpuPkg::opAndi, rt, rs, imm));
				11: progWords.push_back(encI(cpuPkg::opOri, rt, rs, imm));
				12: progWords.push_back(encI(cpuPkg::opLui, rt, 5'd0, imm));
				// sltiu is outside the kept opcodes
				13: progWords.push_back(encI(6'h0b, rt, rs, imm));
				// add with overflow trap is not a kept function
				default: progWords.push_back(encR(6'h20, rd, rs, rt, 5'd0));
			endcase
		end
		runProgram(name, count);
	endtask

	initial begin
		void'($urandom(32'h6cbaa780));
		resetReq    = 1'b0;
		instrF      = '0;
		checking    = 1'b0;
		errors      = 0;
		retireCount = 0;
		testCount   = 0;
		failedTests = 0;
		resetTest();
		aluTest();
		dependencyTest();
		branchTest();
		jumpTest();
		randomTest("random1", lenRandom);
		randomTest("random2", lenRandom);
		$display("%0d tests, %0d with errors, %0d failed checks, %0d assertion failures",
			testCount, failedTests, errors, dut0.asserts0.failures);
		errors += dut0.asserts0.failures;
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// bound from the summed program lengths
	initial begin
		#(watchdogCycles * clkPeriodNs);
		$display("watchdog expired after %0d cycles before the tests completed", watchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/cpuPipeline.sv
verif/tbClockGen.sv
verif/cpuAsserts.sv
verif/cpuTb.sv
